// ==== build.f ====
+incdir+tb
common/isaPkg.sv
common/pipePkg.sv
logic/regFile.sv
logic/controlDecoder.sv
logic/alu.sv
logic/hazardUnit.sv
logic/loadStoreAlign.sv
logic/mipsCore.sv
tb/tbMipsCore.sv

// ==== common/isaPkg.sv ====
`default_nettype none

package isaPkg;

	typedef logic [4:0] regAddr_t;
	typedef logic [31:0] word_t;

	// ======================================================================
	// primary opcodes, only the kept subset
	// ======================================================================
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_LUI   = 6'b001111,
		OP_LB    = 6'b100000,
		OP_LH    = 6'b100001,
		OP_LW    = 6'b100011,
		OP_LBU   = 6'b100100,
		OP_LHU   = 6'b100101,
		OP_SB    = 6'b101000,
		OP_SH    = 6'b101001,
		OP_SW    = 6'b101011
	} opcode_t;

	// r-type function field
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} aluOp_t;

	// same word seen as r-format or i-format
	typedef struct packed {
		opcode_t op;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} rView_t;

	typedef struct packed {
		opcode_t op;
		regAddr_t rs;
		regAddr_t rt;
		logic [15:0] imm;
	} iView_t;

	// j target is rs, rt and imm of the i view taken together
	typedef union packed {
		rView_t r;
		iView_t i;
	} instr_t;

endpackage

`default_nettype wire

// ==== common/pipePkg.sv ====
`default_nettype none

package pipePkg;

	import isaPkg::*;

	// pc after reset, kseg1 boot rom
	localparam word_t resetVector = 32'hBFC00000;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} memSize_t;

	// mem stage has priority over wb
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwdSel_t;

	// ======================================================================
	// decoded control, zero means nop
	// ======================================================================
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic memRead;
		logic aluSrcImm;
		logic regDstRd;
		aluOp_t aluOp;
		memSize_t memSize;
		logic loadSigned;
		logic branch;
		logic branchNe;
		logic jump;
	} ctrl_t;

	// ======================================================================
	// stage registers
	// ======================================================================
	typedef struct packed {
		ctrl_t ctrl;
		logic valid;
		word_t pc;
		word_t rsVal;
		word_t rtVal;
		// raw imm16, shamt sits in bits 10:6
		logic [15:0] imm;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t dest;
	} idEx_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic valid;
		word_t pc;
		word_t aluOut;
		word_t storeData;
		regAddr_t dest;
	} exMem_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic valid;
		word_t pc;
		word_t aluOut;
		word_t loadData;
		regAddr_t dest;
	} memWb_t;

	// data side request, word address
	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic [3:0] byteEn;
		logic read;
	} memReq_t;

	// one retired register write
	typedef struct packed {
		logic valid;
		word_t pc;
		regAddr_t dest;
		word_t data;
	} wbTrace_t;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import isaPkg::*;
(
	input wire aluOp_t op,
	input wire word_t a,
	input wire word_t b,
	input wire logic [4:0] shamt,
	output word_t y
);

	logic lessThan;

	// signed compare for slt and slti
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLT: y = {31'b0, lessThan};
			// shifts take rt, amount from the instruction
			ALU_SLL: y = b << shamt;
			ALU_SRL: y = b >> shamt;
			// lui puts imm16 in the upper half
			ALU_LUI: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
	import isaPkg::*;
	import pipePkg::*;
(
	input wire instr_t instr,
	output ctrl_t ctrl
);

	always_comb begin
		ctrl = '0;
		case (instr.r.op)
			// ==============================================================
			// register-register
			// ==============================================================
			OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (instr.r.funct)
					FN_SLL: ctrl.aluOp = ALU_SLL;
					FN_SRL: ctrl.aluOp = ALU_SRL;
					FN_ADDU: ctrl.aluOp = ALU_ADD;
					FN_SUBU: ctrl.aluOp = ALU_SUB;
					FN_AND: ctrl.aluOp = ALU_AND;
					FN_OR: ctrl.aluOp = ALU_OR;
					FN_XOR: ctrl.aluOp = ALU_XOR;
					FN_SLT: ctrl.aluOp = ALU_SLT;
					// unknown funct acts as nop
					default: ctrl = '0;
				endcase
			end
			// immediate alu ops, result to rt
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				case (instr.i.op)
					OP_SLTI: ctrl.aluOp = ALU_SLT;
					OP_ANDI: ctrl.aluOp = ALU_AND;
					OP_ORI: ctrl.aluOp = ALU_OR;
					OP_LUI: ctrl.aluOp = ALU_LUI;
					default: ctrl.aluOp = ALU_ADD;
				endcase
			end
			// ==============================================================
			// loads and stores, address is rs + simm
			// ==============================================================
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = ALU_ADD;
				ctrl.loadSigned = (instr.i.op == OP_LB) || (instr.i.op == OP_LH);
				case (instr.i.op)
					OP_LB, OP_LBU: ctrl.memSize = MEM_BYTE;
					OP_LH, OP_LHU: ctrl.memSize = MEM_HALF;
					default: ctrl.memSize = MEM_WORD;
				endcase
			end
			OP_SB, OP_SH, OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = ALU_ADD;
				case (instr.i.op)
					OP_SB: ctrl.memSize = MEM_BYTE;
					OP_SH: ctrl.memSize = MEM_HALF;
					default: ctrl.memSize = MEM_WORD;
				endcase
			end
			// branches resolve in decode
			OP_BEQ: ctrl.branch = 1'b1;
			OP_BNE: begin
				ctrl.branch = 1'b1;
				ctrl.branchNe = 1'b1;
			end
			OP_J: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
	import isaPkg::*;
	import pipePkg::*;
(
	input wire regAddr_t rsD,
	input wire regAddr_t rtD,
	input wire regAddr_t rsE,
	input wire regAddr_t rtE,
	input wire regAddr_t destE,
	input wire regAddr_t destM,
	input wire regAddr_t destW,
	input wire ctrl_t ctrlD,
	input wire ctrl_t ctrlE,
	input wire ctrl_t ctrlM,
	input wire ctrl_t ctrlW,
	input wire iStall,
	input wire dStall,
	output fwdSel_t fwdA,
	output fwdSel_t fwdB,
	output logic fwdBrA,
	output logic fwdBrB,
	output logic stallId,
	output logic freeze
);

	logic usesRs;
	logic usesRt;
	logic loadUse;
	logic branchWait;

	// producer writes a nonzero register that the consumer reads
	function automatic logic hit(regAddr_t src, regAddr_t dest, logic writes);
		return writes && dest != '0 && dest == src;
	endfunction

	function automatic fwdSel_t pickFwd(regAddr_t src, regAddr_t dM, regAddr_t dW,
			logic wrM, logic wrW);
		if (hit(src, dM, wrM)) begin
			return FWD_MEM;
		end
		if (hit(src, dW, wrW)) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	// ======================================================================
	// forwarding
	// ======================================================================
	assign fwdA = pickFwd(rsE, destM, destW, ctrlM.regWrite, ctrlW.regWrite);
	assign fwdB = pickFwd(rtE, destM, destW, ctrlM.regWrite, ctrlW.regWrite);

	// branch compare only from mem, wb comes through the register file
	assign fwdBrA = hit(rsD, destM, ctrlM.regWrite && !ctrlM.memRead);
	assign fwdBrB = hit(rtD, destM, ctrlM.regWrite && !ctrlM.memRead);

	// ======================================================================
	// interlocks
	// ======================================================================
	// j carries target bits in rs/rt, i-type alu ops write rt
	assign usesRs = (|ctrlD) && !ctrlD.jump;
	assign usesRt = usesRs && (!ctrlD.aluSrcImm || ctrlD.memWrite);

	// load in execute, one bubble
	assign loadUse = (usesRs && hit(rsD, destE, ctrlE.memRead))
		|| (usesRt && hit(rtD, destE, ctrlE.memRead));

	// alu result still in execute, or load still in memory
	assign branchWait = ctrlD.branch && (hit(rsD, destE, ctrlE.regWrite)
		|| hit(rtD, destE, ctrlE.regWrite)
		|| hit(rsD, destM, ctrlM.memRead)
		|| hit(rtD, destM, ctrlM.memRead));

	assign stallId = loadUse || branchWait;

	// either memory busy, whole pipe holds
	assign freeze = iStall || dStall;

endmodule

`default_nettype wire

// ==== logic/loadStoreAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreAlign
	import isaPkg::*;
	import pipePkg::*;
(
	input wire word_t addr,
	input wire memSize_t size,
	input wire word_t storeData,
	input wire word_t rawLoad,
	input wire loadSigned,
	output logic [3:0] byteEn,
	output word_t laneData,
	output word_t loadData
);

	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	// ======================================================================
	// store side, little-endian lanes
	// ======================================================================
	always_comb begin
		case (size)
			MEM_BYTE: begin
				byteEn = 4'b0001 << addr[1:0];
				laneData = {4{storeData[7:0]}};
			end
			MEM_HALF: begin
				byteEn = addr[1] ? 4'b1100 : 4'b0011;
				laneData = {2{storeData[15:0]}};
			end
			default: begin
				byteEn = 4'b1111;
				laneData = storeData;
			end
		endcase
	end

	// ======================================================================
	// load side
	// ======================================================================
	// addressed lane down to bit 0
	assign loadByte = rawLoad[8*addr[1:0] +: 8];
	assign loadHalf = addr[1] ? rawLoad[31:16] : rawLoad[15:0];

	always_comb begin
		case (size)
			MEM_BYTE: loadData = {{24{loadSigned && loadByte[7]}}, loadByte};
			MEM_HALF: loadData = {{16{loadSigned && loadHalf[15]}}, loadHalf};
			default: loadData = rawLoad;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore
	import isaPkg::*;
	import pipePkg::*;
(
	input wire clk,
	input wire rstN,
	output word_t pcF,
	input wire word_t instrF,
	input wire iStall,
	output memReq_t dReq,
	input wire word_t dRdata,
	input wire dStall,
	output wbTrace_t trace
);

	// fetch/decode register
	logic validD;
	word_t pcD;
	instr_t instrD;

	idEx_t idEx;
	exMem_t exMem;
	memWb_t memWb;

	// hazard decisions
	logic freeze;
	logic stallId;
	fwdSel_t fwdA;
	fwdSel_t fwdB;
	logic fwdBrA;
	logic fwdBrB;

	// decode
	ctrl_t ctrlDec;
	ctrl_t ctrlD;
	word_t rfA;
	word_t rfB;
	word_t brA;
	word_t brB;
	word_t pcPlus4D;
	word_t brTarget;
	word_t jTarget;
	word_t pcNext;
	regAddr_t destD;
	logic taken;

	// execute, memory, writeback
	word_t immE;
	word_t opA;
	word_t opB;
	word_t aluY;
	logic [3:0] laneEn;
	word_t laneData;
	word_t loadData;
	word_t resultW;
	logic wbWrite;

	function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal,
			word_t wbVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// ======================================================================
	// fetch
	// ======================================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcF <= resetVector;
			validD <= 1'b0;
			pcD <= '0;
			instrD <= '0;
		end else if (!freeze && !stallId) begin
			pcF <= pcNext;
			validD <= 1'b1;
			pcD <= pcF;
			instrD <= instrF;
		end
	end

	// ======================================================================
	// decode, branch resolved here
	// ======================================================================
	controlDecoder uDecoder (
		.instr(instrD),
		.ctrl(ctrlDec)
	);

	// empty slot after reset decodes as nop
	assign ctrlD = validD ? ctrlDec : '0;
	assign destD = ctrlD.regDstRd ? instrD.r.rd : instrD.r.rt;

	regFile uRegFile (
		.clk(clk),
		.rstN(rstN),
		.we(wbWrite),
		.raddrA(instrD.r.rs),
		.raddrB(instrD.r.rt),
		.waddr(memWb.dest),
		.wdata(resultW),
		.rdataA(rfA),
		.rdataB(rfB)
	);

	assign brA = fwdBrA ? exMem.aluOut : rfA;
	assign brB = fwdBrB ? exMem.aluOut : rfB;
	assign taken = ctrlD.branch && ((brA == brB) != ctrlD.branchNe);

	// targets relative to the delay slot
	assign pcPlus4D = pcD + 32'd4;
	assign brTarget = pcPlus4D + {{14{instrD.i.imm[15]}}, instrD.i.imm, 2'b00};
	assign jTarget = {pcPlus4D[31:28], instrD.i.rs, instrD.i.rt, instrD.i.imm, 2'b00};
	assign pcNext = ctrlD.jump ? jTarget : (taken ? brTarget : pcF + 32'd4);

	hazardUnit uHazard (
		.rsD(instrD.r.rs),
		.rtD(instrD.r.rt),
		.rsE(idEx.rs),
		.rtE(idEx.rt),
		.destE(idEx.dest),
		.destM(exMem.dest),
		.destW(memWb.dest),
		.ctrlD(ctrlD),
		.ctrlE(idEx.ctrl),
		.ctrlM(exMem.ctrl),
		.ctrlW(memWb.ctrl),
		.iStall(iStall),
		.dStall(dStall),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.fwdBrA(fwdBrA),
		.fwdBrB(fwdBrB),
		.stallId(stallId),
		.freeze(freeze)
	);

	// interlock pushes a bubble into execute
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idEx <= '0;
		end else if (!freeze) begin
			if (stallId) begin
				idEx <= '0;
			end else begin
				idEx.ctrl <= ctrlD;
				idEx.valid <= validD;
				idEx.pc <= pcD;
				idEx.rsVal <= rfA;
				idEx.rtVal <= rfB;
				idEx.imm <= instrD.i.imm;
				idEx.rs <= instrD.r.rs;
				idEx.rt <= instrD.r.rt;
				idEx.dest <= destD;
			end
		end
	end

	// ======================================================================
	// execute
	// ======================================================================
	// andi and ori zero-extend, the rest sign-extend
	assign immE = (idEx.ctrl.aluOp inside {ALU_AND, ALU_OR})
		? {16'h0000, idEx.imm}
		: {{16{idEx.imm[15]}}, idEx.imm};

	assign opA = fwdMux(fwdA, idEx.rsVal, exMem.aluOut, resultW);
	assign opB = fwdMux(fwdB, idEx.rtVal, exMem.aluOut, resultW);

	alu uAlu (
		.op(idEx.ctrl.aluOp),
		.a(opA),
		.b(idEx.ctrl.aluSrcImm ? immE : opB),
		.shamt(idEx.imm[10:6]),
		.y(aluY)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMem <= '0;
		end else if (!freeze) begin
			exMem.ctrl <= idEx.ctrl;
			exMem.valid <= idEx.valid;
			exMem.pc <= idEx.pc;
			exMem.aluOut <= aluY;
			// forwarded rt is the store data
			exMem.storeData <= opB;
			exMem.dest <= idEx.dest;
		end
	end

	// ======================================================================
	// memory
	// ======================================================================
	loadStoreAlign uAlign (
		.addr(exMem.aluOut),
		.size(exMem.ctrl.memSize),
		.storeData(exMem.storeData),
		.rawLoad(dRdata),
		.loadSigned(exMem.ctrl.loadSigned),
		.byteEn(laneEn),
		.laneData(laneData),
		.loadData(loadData)
	);

	always_comb begin
		dReq.addr = {exMem.aluOut[31:2], 2'b00};
		dReq.wdata = laneData;
		dReq.byteEn = (exMem.valid && exMem.ctrl.memWrite) ? laneEn : 4'b0000;
		dReq.read = exMem.valid && exMem.ctrl.memRead;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWb <= '0;
		end else if (!freeze) begin
			memWb.ctrl <= exMem.ctrl;
			memWb.valid <= exMem.valid;
			memWb.pc <= exMem.pc;
			memWb.aluOut <= exMem.aluOut;
			memWb.loadData <= loadData;
			memWb.dest <= exMem.dest;
		end
	end

	// ======================================================================
	// writeback and trace
	// ======================================================================
	assign resultW = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluOut;
	// no write while frozen, once per instruction
	assign wbWrite = memWb.valid && memWb.ctrl.regWrite && !freeze;

	always_comb begin
		trace.valid = wbWrite && memWb.dest != '0;
		trace.pc = memWb.pc;
		trace.dest = memWb.dest;
		trace.data = resultW;
	end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile
	import isaPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire we,
	input wire regAddr_t raddrA,
	input wire regAddr_t raddrB,
	input wire regAddr_t waddr,
	input wire word_t wdata,
	output word_t rdataA,
	output word_t rdataB
);

	// r0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// write-through, so decode sees the wb result in the same cycle
	function automatic word_t readPort(regAddr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (we && waddr == addr) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdataA = readPort(raddrA);
		rdataB = readPort(raddrB);
	end

endmodule

`default_nettype wire

// ==== tb/coreTests.svh ====
`ifndef CORE_TESTS_SVH
`define CORE_TESTS_SVH

// ======================================================================
// alu ops, results in program order
// ======================================================================
task automatic testAluOps();
	startRun();
	emitWrite(iType(OP_ADDIU, 5'd1, 5'd0, 16'h0123), 5'd1, 32'h0000_0123);
	emitWrite(iType(OP_ADDIU, 5'd2, 5'd0, 16'hFFFB), 5'd2, 32'hFFFF_FFFB);
	emitWrite(iType(OP_LUI, 5'd3, 5'd0, 16'h8001), 5'd3, 32'h8001_0000);
	// andi and ori zero-extend
	emitWrite(iType(OP_ORI, 5'd4, 5'd0, 16'hF0F0), 5'd4, 32'h0000_F0F0);
	emitWrite(iType(OP_ANDI, 5'd5, 5'd2, 16'h00FF), 5'd5, 32'h0000_00FB);
	// -5 < -4, signed
	emitWrite(iType(OP_SLTI, 5'd6, 5'd2, 16'hFFFC), 5'd6, 32'h0000_0001);
	emitWrite(iType(OP_SLTI, 5'd7, 5'd1, 16'h0100), 5'd7, 32'h0000_0000);
	emitWrite(rType(FN_ADDU, 5'd8, 5'd1, 5'd4, 5'd0), 5'd8, 32'h0000_F213);
	emitWrite(rType(FN_SUBU, 5'd9, 5'd1, 5'd4, 5'd0), 5'd9, 32'hFFFF_1033);
	emitWrite(rType(FN_AND, 5'd10, 5'd3, 5'd2, 5'd0), 5'd10, 32'h8001_0000);
	emitWrite(rType(FN_OR, 5'd11, 5'd3, 5'd4, 5'd0), 5'd11, 32'h8001_F0F0);
	emitWrite(rType(FN_XOR, 5'd12, 5'd4, 5'd5, 5'd0), 5'd12, 32'h0000_F00B);
	emitWrite(rType(FN_SLT, 5'd13, 5'd3, 5'd1, 5'd0), 5'd13, 32'h0000_0001);
	emitWrite(rType(FN_SLT, 5'd14, 5'd1, 5'd2, 5'd0), 5'd14, 32'h0000_0000);
	emitWrite(rType(FN_SLL, 5'd15, 5'd0, 5'd4, 5'd4), 5'd15, 32'h000F_0F00);
	emitWrite(rType(FN_SRL, 5'd16, 5'd0, 5'd3, 5'd8), 5'd16, 32'h0080_0100);
	// r0 write never shows on trace
	emit(iType(OP_ADDIU, 5'd0, 5'd0, 16'h0005));
	emitWrite(iType(OP_ADDIU, 5'd17, 5'd0, 16'h7FFF), 5'd17, 32'h0000_7FFF);
	finishRun("alu ops");
endtask

// back-to-back chains through mem and wb forwarding
task automatic testForwarding();
	startRun();
	emitWrite(iType(OP_ADDIU, 5'd1, 5'd0, 16'd10), 5'd1, 32'd10);
	emitWrite(iType(OP_ADDIU, 5'd2, 5'd1, 16'd5), 5'd2, 32'd15);
	emitWrite(rType(FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0), 5'd3, 32'd25);
	emitWrite(rType(FN_SUBU, 5'd4, 5'd3, 5'd1, 5'd0), 5'd4, 32'd15);
	emitWrite(rType(FN_ADDU, 5'd4, 5'd4, 5'd4, 5'd0), 5'd4, 32'd30);
	emitWrite(rType(FN_SLL, 5'd5, 5'd0, 5'd4, 5'd2), 5'd5, 32'd120);
	emitWrite(rType(FN_OR, 5'd6, 5'd4, 5'd5, 5'd0), 5'd6, 32'h0000_007E);
	// store data comes from the mem stage
	emit(iType(OP_SW, 5'd6, 5'd0, 16'h0020));
	expectStore(32'h0000_0020, 32'h0000_007E, 4'b1111);
	emitWrite(iType(OP_ADDIU, 5'd7, 5'd6, 16'd1), 5'd7, 32'h0000_007F);
	// r0 in flight is not forwarded
	emit(iType(OP_ADDIU, 5'd0, 5'd0, 16'h0055));
	emitWrite(rType(FN_ADDU, 5'd8, 5'd0, 5'd7, 5'd0), 5'd8, 32'h0000_007F);
	finishRun("forwarding");
endtask

// ======================================================================
// loads, lanes and extension
// ======================================================================
task automatic testLoads();
	startRun();
	// bytes at 0x40 are 7F F2 81 80
	dmem[16] = 32'h8081_F27F;
	dmem[17] = 32'h1234_5678;
	emitWrite(iType(OP_LW, 5'd1, 5'd0, 16'h0040), 5'd1, 32'h8081_F27F);
	// load-use, one bubble
	emitWrite(rType(FN_ADDU, 5'd2, 5'd1, 5'd0, 5'd0), 5'd2, 32'h8081_F27F);
	emitWrite(iType(OP_LB, 5'd3, 5'd0, 16'h0040), 5'd3, 32'h0000_007F);
	emitWrite(iType(OP_LB, 5'd4, 5'd0, 16'h0041), 5'd4, 32'hFFFF_FFF2);
	emitWrite(iType(OP_LBU, 5'd5, 5'd0, 16'h0041), 5'd5, 32'h0000_00F2);
	emitWrite(iType(OP_LB, 5'd6, 5'd0, 16'h0043), 5'd6, 32'hFFFF_FF80);
	emitWrite(iType(OP_LBU, 5'd7, 5'd0, 16'h0042), 5'd7, 32'h0000_0081);
	emitWrite(iType(OP_LH, 5'd8, 5'd0, 16'h0040), 5'd8, 32'hFFFF_F27F);
	emitWrite(iType(OP_LHU, 5'd9, 5'd0, 16'h0040), 5'd9, 32'h0000_F27F);
	emitWrite(iType(OP_LH, 5'd10, 5'd0, 16'h0042), 5'd10, 32'hFFFF_8081);
	emitWrite(iType(OP_LHU, 5'd11, 5'd0, 16'h0046), 5'd11, 32'h0000_1234);
	emitWrite(iType(OP_LW, 5'd12, 5'd0, 16'h0044), 5'd12, 32'h1234_5678);
	emitWrite(iType(OP_ADDIU, 5'd13, 5'd12, 16'd1), 5'd13, 32'h1234_5679);
	emitWrite(iType(OP_LB, 5'd14, 5'd0, 16'h0044), 5'd14, 32'h0000_0078);
	emitWrite(rType(FN_OR, 5'd15, 5'd14, 5'd11, 5'd0), 5'd15, 32'h0000_127C);
	finishRun("loads");
endtask

// stores then read back
task automatic testStores();
	startRun();
	dmem[21] = 32'h1111_1111;
	dmem[22] = 32'h2222_2222;
	dmem[23] = 32'h3333_3333;
	emitWrite(iType(OP_LUI, 5'd1, 5'd0, 16'hA1B2), 5'd1, 32'hA1B2_0000);
	emitWrite(iType(OP_ORI, 5'd1, 5'd1, 16'hC3D4), 5'd1, 32'hA1B2_C3D4);
	emit(iType(OP_SW, 5'd1, 5'd0, 16'h0050));
	expectStore(32'h0000_0050, 32'hA1B2_C3D4, 4'b1111);
	// byte 1 of word 0x54
	emit(iType(OP_SB, 5'd1, 5'd0, 16'h0055));
	expectStore(32'h0000_0054, 32'hD4D4_D4D4, 4'b0010);
	emit(iType(OP_SH, 5'd1, 5'd0, 16'h005A));
	expectStore(32'h0000_0058, 32'hC3D4_C3D4, 4'b1100);
	emit(iType(OP_SH, 5'd1, 5'd0, 16'h005C));
	expectStore(32'h0000_005C, 32'hC3D4_C3D4, 4'b0011);
	emitWrite(iType(OP_LW, 5'd2, 5'd0, 16'h0050), 5'd2, 32'hA1B2_C3D4);
	emitWrite(iType(OP_LW, 5'd3, 5'd0, 16'h0054), 5'd3, 32'h1111_D411);
	emitWrite(iType(OP_LW, 5'd4, 5'd0, 16'h0058), 5'd4, 32'hC3D4_2222);
	emitWrite(iType(OP_LHU, 5'd5, 5'd0, 16'h005C), 5'd5, 32'h0000_C3D4);
	emitWrite(iType(OP_LB, 5'd6, 5'd0, 16'h0055), 5'd6, 32'hFFFF_FFD4);
	finishRun("stores");
endtask

// ======================================================================
// branches and jump, delay slot always runs
// ======================================================================
task automatic testBranches();
	startRun();
	dmem[24] = 32'h0000_0077;
	emitWrite(iType(OP_ADDIU, 5'd1, 5'd0, 16'd1), 5'd1, 32'd1);
	emitWrite(iType(OP_ADDIU, 5'd2, 5'd0, 16'd1), 5'd2, 32'd1);
	// taken to word 6, waits one bubble on r2
	emit(iType(OP_BEQ, 5'd2, 5'd1, 16'd3));
	emitWrite(iType(OP_ADDIU, 5'd3, 5'd0, 16'd3), 5'd3, 32'd3);
	emit(iType(OP_ADDIU, 5'd4, 5'd0, 16'd4));
	emit(iType(OP_ADDIU, 5'd4, 5'd0, 16'd5));
	// not taken, falls through after the slot
	emit(iType(OP_BNE, 5'd2, 5'd1, 16'd5));
	emitWrite(iType(OP_ADDIU, 5'd5, 5'd0, 16'd7), 5'd5, 32'd7);
	emitWrite(iType(OP_ADDIU, 5'd6, 5'd0, 16'd8), 5'd6, 32'd8);
	// taken to word 12
	emit(iType(OP_BNE, 5'd0, 5'd6, 16'd2));
	emitWrite(iType(OP_ADDIU, 5'd7, 5'd0, 16'd10), 5'd7, 32'd10);
	emit(iType(OP_ADDIU, 5'd8, 5'd0, 16'd11));
	emit(jType(pcOf(16)));
	emitWrite(iType(OP_ADDIU, 5'd9, 5'd0, 16'd13), 5'd9, 32'd13);
	emit(iType(OP_ADDIU, 5'd10, 5'd0, 16'd14));
	emit(iType(OP_ADDIU, 5'd10, 5'd0, 16'd15));
	emitWrite(iType(OP_LW, 5'd11, 5'd0, 16'h0060), 5'd11, 32'h0000_0077);
	// load right before the compare, two bubbles, taken to word 20
	emit(iType(OP_BNE, 5'd0, 5'd11, 16'd2));
	emitWrite(iType(OP_ADDIU, 5'd12, 5'd11, 16'd1), 5'd12, 32'h0000_0078);
	emit(iType(OP_ADDIU, 5'd13, 5'd0, 16'd19));
	emitWrite(iType(OP_ADDIU, 5'd14, 5'd0, 16'd20), 5'd14, 32'd20);
	finishRun("branches");
endtask

// same programs, only timing changes
task automatic testRandomStalls();
	stallMode = 1'b1;
	testAluOps();
	testLoads();
	stallMode = 1'b0;
endtask

`endif

// ==== tb/tbMipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore
	import isaPkg::*;
	import pipePkg::*;
();

	// ======================================================================
	// run length
	// ======================================================================
	// words of all seven runs
	// the stall runs repeat alu ops and loads
	localparam int progWords = 18 + 11 + 15 + 11 + 21 + 18 + 15;
	localparam int runCount = 7;
	// four cycles per word and twice that with stalls
	// plus reset and settle time for each run
	localparam int watchdogCycles = 2 * 4 * progWords + 100 * runCount;
	localparam int resetCycles = 10;
	localparam int settleCycles = 20;

	logic clk;
	logic rstN;
	word_t pcF;
	word_t instrF;
	logic iStall;
	logic dStall;
	memReq_t dReq;
	word_t dRdata;
	wbTrace_t trace;

	// instruction rom from resetVector and data ram at address 0
	word_t imem [0:255];
	word_t dmem [0:63];
	int progLen;
	logic stallMode;

	wbTrace_t expTrace [$];
	wbTrace_t gotTrace [$];
	memReq_t expStore [$];
	memReq_t gotStore [$];
	int expReads;
	int gotReads;
	int errorCount;
	int checkCount;

	mipsCore i_dut (
		.clk(clk),
		.rstN(rstN),
		.pcF(pcF),
		.instrF(instrF),
		.iStall(iStall),
		.dReq(dReq),
		.dRdata(dRdata),
		.dStall(dStall),
		.trace(trace)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ======================================================================
	// memory models
	// ======================================================================
	function automatic logic [7:0] imemIndex(word_t pc);
		word_t off;
		off = pc - resetVector;
		return off[9:2];
	endfunction

	// stalls and read data change on the falling edge only
	initial begin
		iStall = 1'b0;
		dStall = 1'b0;
		instrF = '0;
		dRdata = '0;
		void'($urandom(32'h48b9));
		forever begin
			@(negedge clk);
			iStall = stallMode && (($urandom % 4) == 0);
			dStall = stallMode && (($urandom % 4) == 0);
			// garbage while stalled or not reading
			// the core must never consume it
			instrF = iStall ? 32'hFFFF_FFFF : imem[imemIndex(pcF)];
			dRdata = (dStall || !dReq.read) ? 32'h0BAD_0BAD : dmem[dReq.addr[7:2]];
		end
	end

	// a held request completes on the first unfrozen edge
	always @(posedge clk) begin
		if (rstN && !iStall && !dStall) begin
			for (int b = 0; b < 4; b++) begin
				if (dReq.byteEn[b]) begin
					dmem[dReq.addr[7:2]][8*b +: 8] <= dReq.wdata[8*b +: 8];
				end
			end
			if (dReq.byteEn != 4'b0000) begin
				gotStore.push_back(dReq);
			end
			if (dReq.read) begin
				gotReads++;
			end
		end
		// trace.valid pulses once per retired write
		if (rstN && trace.valid) begin
			gotTrace.push_back(trace);
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, the run did not finish",
			watchdogCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ======================================================================
	// program building
	// ======================================================================
	function automatic word_t pcOf(int idx);
		return resetVector + 32'(idx) * 32'd4;
	endfunction

	// background differs per word
	function automatic word_t backgroundWord(int idx);
		return {16'hC0DE, idx[7:0], ~idx[7:0]};
	endfunction

	function automatic word_t rType(funct_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt,
			logic [4:0] sh);
		instr_t w;
		w.r.op = OP_RTYPE;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = sh;
		w.r.funct = fn;
		return w;
	endfunction

	// assembly operand order with rt first
	function automatic word_t iType(opcode_t op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
		instr_t w;
		w.i.op = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic word_t jType(word_t target);
		return {OP_J, target[27:2]};
	endfunction

	task automatic emit(word_t w);
		imem[progLen] = w;
		progLen++;
	endtask

	// instruction plus the register write it must retire
	task automatic emitWrite(word_t w, regAddr_t dest, word_t data);
		wbTrace_t t;
		t.valid = 1'b1;
		t.pc = pcOf(progLen);
		t.dest = dest;
		t.data = data;
		expTrace.push_back(t);
		// opcodes 100xxx are loads and each reads memory once
		if (w[31:29] == 3'b100) begin
			expReads++;
		end
		emit(w);
	endtask

	task automatic expectStore(word_t addr, word_t wdata, logic [3:0] byteEn);
		memReq_t r;
		r.addr = addr;
		r.wdata = wdata;
		r.byteEn = byteEn;
		r.read = 1'b0;
		expStore.push_back(r);
	endtask

	// ======================================================================
	// compare tasks
	// ======================================================================
	task automatic checkTrace(wbTrace_t exp, wbTrace_t got, string name);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s write pc %h r%0d = %h, expected pc %h r%0d = %h",
				$time, name, got.pc, got.dest, got.data, exp.pc, exp.dest, exp.data);
		end
	endtask

	task automatic checkStore(memReq_t exp, memReq_t got, string name);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s store %h data %h be %b, expected %h data %h be %b",
				$time, name, got.addr, got.wdata, got.byteEn, exp.addr, exp.wdata, exp.byteEn);
		end
	endtask

	// ======================================================================
	// run control
	// ======================================================================
	// reset goes low first and the program is loaded under reset
	task automatic startRun();
		@(negedge clk);
		rstN = 1'b0;
		for (int i = 0; i < 256; i++) begin
			// unused words jump to themselves
			imem[i] = jType(pcOf(i));
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = backgroundWord(i);
		end
		progLen = 0;
		expReads = 0;
		gotReads = 0;
		expTrace.delete();
		gotTrace.delete();
		expStore.delete();
		gotStore.delete();
	endtask

	task automatic finishRun(string name);
		int waited;
		int limit;
		string label;
		label = stallMode ? {name, " with stalls"} : name;
		limit = (stallMode ? 8 : 4) * progLen + 60;
		waited = 0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
		while ((gotTrace.size() < expTrace.size() || gotStore.size() < expStore.size())
				&& waited < limit) begin
			@(posedge clk);
			waited++;
		end
		// catch anything retiring late
		repeat (settleCycles) @(posedge clk);
		$display("run %s: %0d writes, %0d stores, %0d reads", label, gotTrace.size(),
			gotStore.size(), gotReads);
		if (gotTrace.size() != expTrace.size()) begin
			errorCount++;
			$display("ERROR: %s retired %0d register writes, expected %0d",
				label, gotTrace.size(), expTrace.size());
		end
		if (gotStore.size() != expStore.size()) begin
			errorCount++;
			$display("ERROR: %s issued %0d stores, expected %0d",
				label, gotStore.size(), expStore.size());
		end
		if (gotReads != expReads) begin
			errorCount++;
			$display("ERROR: %s issued %0d data reads, expected %0d",
				label, gotReads, expReads);
		end
		for (int i = 0; i < expTrace.size() && i < gotTrace.size(); i++) begin
			checkTrace(expTrace[i], gotTrace[i], label);
		end
		for (int i = 0; i < expStore.size() && i < gotStore.size(); i++) begin
			checkStore(expStore[i], gotStore[i], label);
		end
	endtask

	`include "coreTests.svh"

	initial begin
		rstN = 1'b0;
		stallMode = 1'b0;
		progLen = 0;
		errorCount = 0;
		checkCount = 0;
		testAluOps();
		testForwarding();
		testLoads();
		testStores();
		testBranches();
		testRandomStalls();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
